//--- flist.f
input_mux_pkg.sv
sysreg_read.sv
read_blend.sv
input_mux_top.sv
input_mux_assert.sv
input_mux_tb.sv

//--- input_mux_assert.sv
/*
 * Concurrent checks for the read-data input multiplexer, bound to the top
 * level. Expected words are rebuilt from the ports and the package bit
 * positions; fail_count is read by the testbench for its summary.
 */
`timescale 1ns/1ns

module input_mux_assert (
   input  logic                                clk,
   input  logic                                rst_n,
   input  input_mux_pkg::bus_req_t             req,
   input  input_mux_pkg::irq_state_t           irq,
   input  logic [input_mux_pkg::ext_w-1:0]     din,
   input  logic [input_mux_pkg::word_w-1:0]    sram_data,
   input  logic [input_mux_pkg::word_w-1:0]    ram_data,
   input  logic                                sa00,
   input  logic                                qack,
   input  logic                                sram_ack,
   input  logic                                sysreg_ack,
   input  logic [input_mux_pkg::word_w-1:0]    di
);
   import input_mux_pkg::*;

   int                fail_count = 0; // Failed checks so far
   bit                armed = 1'b0;   // Set once $past has history
   logic [1:0]        sel;            // Register select field
   logic              flag;           // Blend flag as it will be registered
   logic [word_w-1:0] ext_word;       // din with zero extension
   logic [word_w-1:0] exp_csr;        // Expected system register word
   logic [word_w-1:0] exp_cap;        // Word the stage should capture
   logic [word_w-1:0] cap_prev;       // exp_cap of the previous edge
   logic [word_w-1:0] exp_merge;      // Expected di while the blend is open
   logic [word_w-1:0] shadr;          // Address shifted right by one

   // Expected register word set bit by bit from the fixed positions
   function automatic logic [word_w-1:0] csr_expect(input logic [1:0] s,
                                                    input irq_state_t st);
      logic [word_w-1:0] w;
      w = '0;
      if (s == sel_mip) begin
         w[bit_sw]   = st.msip;
         w[bit_tm]   = st.mtip;
         w[bit_ext]  = st.meip;
         w[bit_tinc] = st.mtimeincip;
         w[bit_ret]  = st.mrinstretip;
      end else if (s == sel_mie) begin
         w[bit_sw]   = st.msie;
         w[bit_tm]   = st.mtie;
         w[bit_ext]  = st.meie;
         w[bit_tinc] = st.mtimeincie;
         w[bit_ret]  = st.mrinstretie;
      end else if (s == sel_mstatus) begin
         w[bit_sw]  = st.mie;  // Global enable
         w[bit_tm]  = st.mpie; // Previous enable
         w[bit_ext] = 1'b1;
         w[bit_one] = 1'b1;
      end
      return w;
   endfunction

   always @(posedge clk) begin
      armed    <= 1'b1;
      cap_prev <= exp_cap;
   end

   assign sel       = req.adr[sel_hi:sel_lo];
   assign flag      = sa00 | qack | sram_ack;
   assign ext_word  = {{(word_w-ext_w){1'b0}}, din};
   assign exp_csr   = csr_expect(sel, irq);
   assign exp_cap   = !req.stb ? sram_data : (sel == sel_ext) ? ext_word : exp_csr;
   assign shadr     = {req.sra_msb, req.adr[word_w-1:1]};
   assign exp_merge = (ram_data & cap_prev) | (~ram_data & shadr);

   // ==================================================
   // Acknowledge and reset
   // ==================================================
   a_ack: assert property (@(posedge clk) sysreg_ack == (req.stb && sel != sel_ext))
      else begin
         $error("ERROR sysreg_ack 0x%h, adr 0x%08h stb 0x%h", $sampled(sysreg_ack),
                $sampled(req.adr), $sampled(req.stb));
         fail_count++;
      end

   a_reset: assert property (@(posedge clk) armed && !$past(rst_n) |-> di == ram_data)
      else begin
         $error("ERROR di 0x%08h after reset, ram_data 0x%08h", $sampled(di),
                $sampled(ram_data));
         fail_count++;
      end

   // ==================================================
   // Capture and blend, one cycle after the request
   // ==================================================
   a_pass: assert property (@(posedge clk)
      armed && $past(rst_n) && !$past(flag) |-> di == ram_data)
      else begin
         $error("ERROR di 0x%08h, pass expected 0x%08h", $sampled(di), $sampled(ram_data));
         fail_count++;
      end

   a_csr: assert property (@(posedge clk)
      armed && $past(rst_n) && $past(req.stb && sel != sel_ext && sa00) && ram_data == '1
      |-> di == $past(exp_csr))
      else begin
         $error("ERROR di 0x%08h on system register read, expected 0x%08h",
                $sampled(di), $sampled(cap_prev));
         fail_count++;
      end

   a_ext: assert property (@(posedge clk)
      armed && $past(rst_n) && $past(req.stb && sel == sel_ext && (qack || sram_ack))
      && ram_data == '1 |-> di == $past(ext_word))
      else begin
         $error("ERROR di 0x%08h on external port read, expected 0x%08h",
                $sampled(di), $sampled(cap_prev));
         fail_count++;
      end

   a_sram: assert property (@(posedge clk)
      armed && $past(rst_n) && $past(!req.stb && (qack || sram_ack)) && ram_data == '1
      |-> di == $past(sram_data))
      else begin
         $error("ERROR di 0x%08h on SRAM read, expected 0x%08h",
                $sampled(di), $sampled(cap_prev));
         fail_count++;
      end

   a_shift: assert property (@(posedge clk)
      armed && $past(rst_n) && $past(flag) && ram_data == '0 |-> di == shadr)
      else begin
         $error("ERROR di 0x%08h, shifted address 0x%08h", $sampled(di), $sampled(shadr));
         fail_count++;
      end

   // Mask one takes the captured bit and mask zero the shifted address bit
   a_merge: assert property (@(posedge clk)
      armed && $past(rst_n) && $past(flag)
      |-> di == ((ram_data & $past(exp_cap)) | (~ram_data & shadr)))
      else begin
         $error("ERROR di 0x%08h, expected 0x%08h, ram_data 0x%08h", $sampled(di),
                $sampled(exp_merge), $sampled(ram_data));
         fail_count++;
      end

endmodule

//--- input_mux_pkg.sv
/*
 * Shared widths, address fields, register bit positions and bus types for
 * the read-data input multiplexer. Imported by every RTL module, by the
 * testbench and by the bound assertion module.
 */
package input_mux_pkg;

   // ==================================================
   // Widths
   // ==================================================
   localparam int word_w = 32; // Data and address width
   localparam int ext_w  = 8;  // External data port, zero-extended on read

   // Register select field inside the address
   localparam int sel_hi = 29;
   localparam int sel_lo = 28;

   // Select codes on adr[29:28]
   localparam logic [1:0] sel_ext     = 2'd0; // External port, no ack
   localparam logic [1:0] sel_mip     = 2'd1; // Machine interrupt pending
   localparam logic [1:0] sel_mie     = 2'd2; // Machine interrupt enable
   localparam logic [1:0] sel_mstatus = 2'd3; // Machine status

   // ==================================================
   // Bit positions in the system registers
   // ==================================================
   localparam int bit_sw   = 3;  // Software source, mie in mstatus
   localparam int bit_tm   = 7;  // Timer source, mpie in mstatus
   localparam int bit_ext  = 11; // External source, reads one in mstatus
   localparam int bit_one  = 12; // Always one in mstatus
   localparam int bit_tinc = 16; // Time-increment source
   localparam int bit_ret  = 17; // Retired-instruction source

   // Interrupt state as kept by the core
   typedef struct packed {
      logic mie;         // Global enable
      logic mpie;        // Previous global enable
      logic msie;        // Software enable
      logic mtie;        // Timer enable
      logic meie;        // External enable
      logic mtimeincie;  // Time-increment enable
      logic mrinstretie; // Retired-instruction enable
      logic msip;        // Software pending
      logic mtip;        // Timer pending
      logic meip;        // External pending
      logic mtimeincip;  // Time-increment pending
      logic mrinstretip; // Retired-instruction pending
   } irq_state_t;

   // Field view of a system register word, one flag per bit position
   // Reserved ranges are sized from the positions so the view stays 32 bits
   typedef struct packed {
      logic [word_w-1:bit_ret+1]   rsv_hi;  // 31:18
      logic                        ret;     // 17
      logic                        tinc;    // 16
      logic [bit_tinc-1:bit_one+1] rsv_mid; // 15:13
      logic                        one;     // 12
      logic                        ext;     // 11
      logic [bit_ext-1:bit_tm+1]   rsv_b;   // 10:8
      logic                        tm;      // 7
      logic [bit_tm-1:bit_sw+1]    rsv_c;   // 6:4
      logic                        sw;      // 3
      logic [bit_sw-1:0]           rsv_lo;  // 2:0
   } csr_fields_t;

   /* Built through f, consumed through raw.
    * mip and mie share the layout, mstatus reuses sw, tm, ext and one
    */
   typedef union packed {
      logic [word_w-1:0] raw; // Word as seen by the read path
      csr_fields_t       f;   // Flag view for construction
   } csr_word_u;

   // ==================================================
   // Core-side request
   // ==================================================
   typedef struct packed {
      logic [word_w-1:0] adr;     // Byte address
      logic              stb;     // High selects I/O, low selects SRAM
      logic              sra_msb; // Shifted into bit 31 of adr >> 1
   } bus_req_t;

endpackage

//--- input_mux_tb.sv
/*
 * Testbench for the read-data input multiplexer. Runs reset, acknowledge,
 * system register, external/SRAM and blend tests from LFSR stimulus; the
 * bound assertion module does the checking.
 */
`timescale 1ns/1ns

module input_mux_tb;
   import input_mux_pkg::*;

   // ==================================================
   // Run length and seed
   // ==================================================
   localparam logic [31:0] seed = 32'd76282;
   localparam int reset_len  = 5;   // Cycles with rst_n low
   localparam int post_reset = 4;   // Random cycles after release
   localparam int n_ack      = 64;
   localparam int n_csr      = 48;
   localparam int n_io       = 64;
   localparam int n_blend    = 128;
   localparam int n_tests    = 5;   // Two closing cycles each
   localparam int max_cycles =
      2 * (reset_len + post_reset + n_ack + n_csr + n_io + n_blend + 2 * n_tests + 1);

   logic              clk;
   logic              rst_n;
   bus_req_t          req;
   irq_state_t        irq;
   logic [ext_w-1:0]  din;
   logic [word_w-1:0] sram_data;
   logic [word_w-1:0] ram_data;
   logic              sa00;
   logic              qack;
   logic              sram_ack;
   logic              sysreg_ack;
   logic [word_w-1:0] di;

   logic [31:0] lfsr;          // Random state
   int          cycle_count;   // Watchdog
   int          mark;          // Error count at the start of a test
   int          tests_run;
   int          tests_failed;

   input_mux_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .irq        (irq),
      .din        (din),
      .sram_data  (sram_data),
      .ram_data   (ram_data),
      .sa00       (sa00),
      .qack       (qack),
      .sram_ack   (sram_ack),
      .sysreg_ack (sysreg_ack),
      .di         (di)
   );

   // Checker instance lands inside dut as chk
   bind input_mux_top input_mux_assert chk (
      .clk (clk), .rst_n (rst_n), .req (req), .irq (irq), .din (din),
      .sram_data (sram_data), .ram_data (ram_data), .sa00 (sa00), .qack (qack),
      .sram_ack (sram_ack), .sysreg_ack (sysreg_ack), .di (di)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk; // 100 ns period
   end

   // ==================================================
   // Random source
   // ==================================================

   // Galois LFSR over x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One LFSR step per bit taken, each new bit enters at the LSB
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // ==================================================
   // Stimulus helpers
   // ==================================================
   task automatic scramble_inputs();
      logic [31:0] r;
      req.adr     = take_bits(word_w);
      r           = take_bits(2);
      req.stb     = r[0];
      req.sra_msb = r[1];
      r           = take_bits(12);
      irq         = r[11:0];
      r           = take_bits(ext_w);
      din         = r[ext_w-1:0];
      sram_data   = take_bits(word_w);
      ram_data    = take_bits(word_w);
   endtask

   task automatic random_flags();
      logic [31:0] r;
      r        = take_bits(3);
      sa00     = r[0];
      qack     = r[1];
      sram_ack = r[2];
   endtask

   // Inputs held two more edges so the last request is checked in its own test
   task automatic close_test(input string name, input int cycles);
      int errs;
      repeat (2) @(negedge clk);
      errs = dut.chk.fail_count - mark;
      mark = dut.chk.fail_count;
      tests_run++;
      if (errs != 0)
         tests_failed++;
      $display("test %-8s %4d cycles  %0d errors  %s", name, cycles, errs,
               (errs == 0) ? "ok" : "failed");
   endtask

   // ==================================================
   // Watchdog
   // ==================================================
   initial begin
      cycle_count = 0;
      while (cycle_count < max_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("** FAIL **");
      $finish;
   end

   // ==================================================
   // Test sequence
   // ==================================================
   initial begin
      logic [31:0] r;
      lfsr         = seed;
      rst_n        = 1'b0;
      req          = '0;
      irq          = '0;
      din          = '0;
      sram_data    = '0;
      ram_data     = '0;
      sa00         = 1'b0;
      qack         = 1'b0;
      sram_ack     = 1'b0;
      mark         = 0;
      tests_run    = 0;
      tests_failed = 0;

      // Flags held low through reset and random traffic after release
      for (int i = 0; i < reset_len; i++) begin
         @(negedge clk);
         scramble_inputs();
         {sa00, qack, sram_ack} = 3'b000;
      end
      rst_n = 1'b1;
      for (int i = 0; i < post_reset; i++) begin
         @(negedge clk);
         scramble_inputs();
         random_flags();
      end
      close_test("reset", reset_len + post_reset);

      // Acknowledge over any select and strobe
      for (int i = 0; i < n_ack; i++) begin
         @(negedge clk);
         scramble_inputs();
         random_flags();
      end
      close_test("ack", n_ack);

      // Strobed system register reads with sa00 high and an all ones mask
      for (int i = 0; i < n_csr; i++) begin
         @(negedge clk);
         scramble_inputs();
         r                      = take_bits(2);
         req.stb                = 1'b1;
         req.adr[sel_hi:sel_lo] = (r[1:0] == sel_ext) ? sel_mstatus : r[1:0];
         random_flags();
         sa00                   = 1'b1;
         ram_data               = '1;
      end
      close_test("csr", n_csr);

      // External port when strobed, SRAM otherwise
      for (int i = 0; i < n_io; i++) begin
         @(negedge clk);
         scramble_inputs();
         if (req.stb)
            req.adr[sel_hi:sel_lo] = sel_ext;
         r        = take_bits(2);
         sa00     = 1'b0;
         qack     = r[0];
         sram_ack = r[1] | ~r[0]; // At least one ack
         ram_data = '1;
      end
      close_test("ext_sram", n_io);

      // Random blend mask with an all zero mask now and then
      for (int i = 0; i < n_blend; i++) begin
         @(negedge clk);
         scramble_inputs();
         random_flags();
         r = take_bits(2);
         if (r[1:0] == 2'b00)
            ram_data = '0;
      end
      close_test("blend", n_blend);

      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
               dut.chk.fail_count);
      if (dut.chk.fail_count == 0 && tests_failed == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- input_mux_top.sv
/*
 * Read-data input multiplexer of the core. Joins the I/O decode and the
 * capture-and-blend stage; sysreg_ack is combinational, di follows one
 * cycle after the request.
 */
`timescale 1ns/1ns

module input_mux_top (
   input  logic                                clk,
   input  logic                                rst_n,      // Synchronous, active low
   input  input_mux_pkg::bus_req_t             req,        // Address, strobe, shift-in bit
   input  input_mux_pkg::irq_state_t           irq,        // Interrupt state for the CSR words
   input  logic [input_mux_pkg::ext_w-1:0]     din,        // External data port
   input  logic [input_mux_pkg::word_w-1:0]    sram_data,  // SRAM read word
   input  logic [input_mux_pkg::word_w-1:0]    ram_data,   // Internal RAM word
   input  logic                                sa00,       // Main select
   input  logic                                qack,       // Qualified acknowledge
   input  logic                                sram_ack,   // SRAM acknowledge
   output logic                                sysreg_ack, // Ack from mip/mie/mstatus
   output logic [input_mux_pkg::word_w-1:0]    di          // Multiplexer output
);
   import input_mux_pkg::*;

   logic [word_w-1:0] io_word; // Decoded I/O word, valid when stb is high

   // ==================================================
   // I/O decode, zero cycles
   // ==================================================
   sysreg_read u_sysreg_read (
      .req        (req),
      .irq        (irq),
      .din        (din),
      .io_word    (io_word),
      .sysreg_ack (sysreg_ack)
   );

   // ==================================================
   // Capture and blend, one cycle
   // ==================================================
   read_blend u_read_blend (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .io_word   (io_word),
      .sram_data (sram_data),
      .ram_data  (ram_data),
      .sa00      (sa00),
      .qack      (qack),
      .sram_ack  (sram_ack),
      .di        (di)
   );

endmodule

//--- read_blend.sv
/*
 * Capture-and-blend stage of the input multiplexer. Registers the SRAM or
 * I/O word and the blend flag, then merges the captured word with the
 * right-shifted address under control of the internal RAM word.
 */
`timescale 1ns/1ns

module read_blend (
   input  logic                                clk,
   input  logic                                rst_n,     // Synchronous, active low
   input  input_mux_pkg::bus_req_t             req,       // Address, strobe, shift-in bit
   input  logic [input_mux_pkg::word_w-1:0]    io_word,   // From the I/O decode
   input  logic [input_mux_pkg::word_w-1:0]    sram_data, // SRAM read word
   input  logic [input_mux_pkg::word_w-1:0]    ram_data,  // Internal RAM word, also blend mask
   input  logic                                sa00,      // Main select
   input  logic                                qack,      // Qualified acknowledge
   input  logic                                sram_ack,  // SRAM acknowledge
   output logic [input_mux_pkg::word_w-1:0]    di         // Multiplexer output
);
   import input_mux_pkg::*;

   logic [word_w-1:0] cap_next;  // Word to capture this edge
   logic [word_w-1:0] cap_q;     // Captured read word
   logic              blend_d;   // Next blend flag
   logic              blend_q;   // Registered blend flag
   logic [word_w-1:0] shadr;     // adr >> 1 with sra_msb on top
   logic [word_w-1:0] merged;    // Bitwise blend

   // ==================================================
   // Capture path
   // ==================================================

   // Strobe high means an I/O access, low means SRAM
   assign cap_next = req.stb ? io_word : sram_data;

   // Any acknowledge or the main select opens the blend next cycle
   assign blend_d = sa00 | qack | sram_ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cap_q   <= '0;
         blend_q <= 1'b0;
      end else begin
         cap_q   <= cap_next; // New read may start every cycle
         blend_q <= blend_d;
      end
   end

   // ==================================================
   // Blend path
   // ==================================================

   // Shift uses the current address, not the captured one
   assign shadr = {req.sra_msb, req.adr[word_w-1:1]};

   // ram_data one takes the captured bit, zero takes the shifted address bit
   assign merged = (ram_data & cap_q) | (~ram_data & shadr);

   always_comb begin
      if (blend_q)
         di = merged;
      else
         di = ram_data; // Plain pass of the internal RAM word
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the input multiplexer testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert --timescale 1ns/1ns -j 0 \
   --top-module input_mux_tb -f flist.f -o Vinput_mux_tb > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

# Raise the error limit so every failed assertion is logged and counted
./obj_dir/Vinput_mux_tb +verilator+error+limit+10000 > sim.log 2>&1

grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation did not complete, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

//--- sysreg_read.sv
/*
 * I/O read decode. Picks the zero-extended external port or one of the
 * machine interrupt pending, enable and status words by adr[29:28], and
 * gives the system-register acknowledge in the same cycle.
 */
`timescale 1ns/1ns

module sysreg_read (
   input  input_mux_pkg::bus_req_t             req,        // Address and strobe
   input  input_mux_pkg::irq_state_t           irq,        // Interrupt state
   input  logic [input_mux_pkg::ext_w-1:0]     din,        // External data port
   output logic [input_mux_pkg::word_w-1:0]    io_word,    // Selected I/O word
   output logic                                sysreg_ack  // Ack for mip/mie/mstatus
);
   import input_mux_pkg::*;

   logic [1:0]        sel;      // Register select field
   logic [word_w-1:0] ext_word; // External port, zero-extended
   csr_word_u         mip_w;    // Pending register
   csr_word_u         mie_w;    // Enable register
   csr_word_u         mst_w;    // Status register

   assign sel = req.adr[sel_hi:sel_lo];

   // Upper bits of a narrow port read as zero
   assign ext_word = {{(word_w-ext_w){1'b0}}, din};

   // ==================================================
   // System register words
   // ==================================================

   // MIP
   always_comb begin
      mip_w      = '0;
      mip_w.f.sw   = irq.msip;
      mip_w.f.tm   = irq.mtip;
      mip_w.f.ext  = irq.meip;
      mip_w.f.tinc = irq.mtimeincip;
      mip_w.f.ret  = irq.mrinstretip;
   end

   // MIE, same layout as MIP
   always_comb begin
      mie_w      = '0;
      mie_w.f.sw   = irq.msie;
      mie_w.f.tm   = irq.mtie;
      mie_w.f.ext  = irq.meie;
      mie_w.f.tinc = irq.mtimeincie;
      mie_w.f.ret  = irq.mrinstretie;
   end

   /* MSTATUS. Only machine mode exists, so MPP (bits 12:11)
    * is hardwired to 2'b11
    */
   always_comb begin
      mst_w     = '0;
      mst_w.f.sw  = irq.mie;  // Bit 3
      mst_w.f.tm  = irq.mpie; // Bit 7
      mst_w.f.ext = 1'b1;     // MPP low bit
      mst_w.f.one = 1'b1;     // MPP high bit
   end

   // ==================================================
   // Select and acknowledge
   // ==================================================
   always_comb begin
      unique case (sel)
         sel_ext:     io_word = ext_word;
         sel_mip:     io_word = mip_w.raw;
         sel_mie:     io_word = mie_w.raw;
         sel_mstatus: io_word = mst_w.raw;
         default:     io_word = ext_word;
      endcase
   end

   // External port reads are acked by the device, not here
   assign sysreg_ack = req.stb & (sel != sel_ext);

endmodule
